//--- design/fft_pkg.sv
package fft_pkg;

    // Sample format
    localparam int DATA_W  = 16;      // Real or imaginary part
    localparam int TW_FRAC = 14;      // Q2.14 twiddle, 1.0 = 16384

    // Transform size and twiddle addressing
    localparam int N_POINTS = 16;
    // A radix-2 stage needs W^0 .. W^(N/2-1)
    localparam int TW_IDX_W = $clog2(N_POINTS / 2);

    // Strobe to product, ROM + partial products + add/shift
    localparam int MULT_LATENCY = 3;

    // One signed sample component
    typedef logic signed [DATA_W-1:0] sample_t;

    // Rotated b can exceed the input range by sqrt(2), one extra bit
    typedef logic signed [DATA_W:0] prod_t;

    // Which half of the butterfly result goes out this cycle
    typedef enum logic {
        PHASE_SUM  = 1'b0,   // (a + bW)/2 first
        PHASE_DIFF = 1'b1    // (a - bW)/2 second
    } ser_phase_e;

endpackage

//--- design/twiddle_rom.sv
`timescale 1ns/10ps

module twiddle_rom import fft_pkg::*; (
    input  logic                clk,
    input  logic [TW_IDX_W-1:0] tw_idx,   // k of W^k
    output sample_t             tw_re,    // cos(2*pi*k/16)
    output sample_t             tw_im     // -sin(2*pi*k/16)
);

    // Values scaled by 16384 and rounded to nearest
    always_ff @(posedge clk) begin
        case (tw_idx)
            3'd0: begin
                tw_re <=  16'sd16384;
                tw_im <=  16'sd0;
            end
            3'd1: begin                 // 22.5 deg
                tw_re <=  16'sd15137;
                tw_im <= -16'sd6270;
            end
            3'd2: begin                 // 45 deg
                tw_re <=  16'sd11585;
                tw_im <= -16'sd11585;
            end
            3'd3: begin
                tw_re <=  16'sd6270;
                tw_im <= -16'sd15137;
            end
            3'd4: begin                 // -j
                tw_re <=  16'sd0;
                tw_im <= -16'sd16384;
            end
            3'd5: begin
                tw_re <= -16'sd6270;
                tw_im <= -16'sd15137;
            end
            3'd6: begin                 // 135 deg
                tw_re <= -16'sd11585;
                tw_im <= -16'sd11585;
            end
            default: begin              // k = 7
                tw_re <= -16'sd15137;
                tw_im <= -16'sd6270;
            end
        endcase
    end

endmodule

//--- design/twiddle_mult.sv
`timescale 1ns/10ps

module twiddle_mult import fft_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  sample_t             b_re,
    input  sample_t             b_im,
    input  logic [TW_IDX_W-1:0] tw_idx,
    output prod_t               prod_re,
    output prod_t               prod_im,
    output logic                prod_valid
);

    sample_t                     tw_re, tw_im;       // From ROM, one cycle after strobe
    sample_t                     b_re_d, b_im_d;     // b aligned with the twiddle
    logic signed [2*DATA_W-1:0]  pp_rr, pp_ii, pp_ri, pp_ir;
    logic signed [2*DATA_W:0]    re_full, im_full;   // Full width before scaling
    logic [MULT_LATENCY-1:0]     vld_sr;             // Valid follows the data

    twiddle_rom i_twiddle_rom (
        .clk    (clk),
        .tw_idx (tw_idx),
        .tw_re  (tw_re),
        .tw_im  (tw_im)
    );

    // Stage 0: hold b while the ROM reads
    always_ff @(posedge clk) begin
        if (in_valid) begin
            b_re_d <= b_re;
            b_im_d <= b_im;
        end
    end

    // Stage 1: four partial products
    always_ff @(posedge clk) begin
        if (vld_sr[0]) begin
            pp_rr <= b_re_d * tw_re;
            pp_ii <= b_im_d * tw_im;
            pp_ri <= b_re_d * tw_im;
            pp_ir <= b_im_d * tw_re;
        end
    end

    assign re_full = pp_rr - pp_ii;   // Re{b*W}
    assign im_full = pp_ri + pp_ir;   // Im{b*W}

    // Stage 2: drop Q2.14 fraction, truncating toward -inf
    always_ff @(posedge clk) begin
        if (vld_sr[1]) begin
            prod_re <= prod_t'(re_full >>> TW_FRAC);
            prod_im <= prod_t'(im_full >>> TW_FRAC);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) vld_sr <= '0;
        else        vld_sr <= {vld_sr[MULT_LATENCY-2:0], in_valid};
    end

    assign prod_valid = vld_sr[MULT_LATENCY-1];

endmodule

//--- design/butterfly.sv
`timescale 1ns/10ps

module butterfly import fft_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,    // Strobe that came with a
    input  sample_t a_re,
    input  sample_t a_im,
    input  prod_t   prod_re,     // b*W^k from the multiplier
    input  prod_t   prod_im,
    input  logic    prod_valid,
    output sample_t sum_re,      // (a + bW)/2
    output sample_t sum_im,
    output sample_t diff_re,     // (a - bW)/2
    output sample_t diff_im,
    output logic    bf_valid
);

    sample_t                  a_re_dl [MULT_LATENCY];   // a waits for the product
    sample_t                  a_im_dl [MULT_LATENCY];
    logic signed [DATA_W+1:0] s_re, s_im, d_re, d_im;   // One guard bit over prod_t

    // First tap only loads on a strobe, the rest shift freely
    always_ff @(posedge clk) begin
        if (in_valid) begin
            a_re_dl[0] <= a_re;
            a_im_dl[0] <= a_im;
        end
        for (int i = 1; i < MULT_LATENCY; i++) begin
            a_re_dl[i] <= a_re_dl[i-1];
            a_im_dl[i] <= a_im_dl[i-1];
        end
    end

    assign s_re = a_re_dl[MULT_LATENCY-1] + prod_re;
    assign s_im = a_im_dl[MULT_LATENCY-1] + prod_im;
    assign d_re = a_re_dl[MULT_LATENCY-1] - prod_re;
    assign d_im = a_im_dl[MULT_LATENCY-1] - prod_im;

    // Halve both outputs, result fits DATA_W for |a|,|b| <= 16383
    always_ff @(posedge clk) begin
        if (prod_valid) begin
            sum_re  <= sample_t'(s_re >>> 1);
            sum_im  <= sample_t'(s_im >>> 1);
            diff_re <= sample_t'(d_re >>> 1);
            diff_im <= sample_t'(d_im >>> 1);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) bf_valid <= 1'b0;
        else        bf_valid <= prod_valid;
    end

endmodule

//--- design/pair_serializer.sv
`timescale 1ns/10ps

module pair_serializer import fft_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,
    input  sample_t sum_re,
    input  sample_t sum_im,
    input  sample_t diff_re,
    input  sample_t diff_im,
    output sample_t out_re,
    output sample_t out_im,
    output logic    out_valid
);

    ser_phase_e phase;        // Half being sent next
    logic       in_valid_d;   // Second slot of the pair
    logic       en;

    assign en = in_valid | in_valid_d;   // Busy for two cycles per strobe

    // Phase toggles while enabled, falls back to sum when idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)                  phase <= PHASE_SUM;
        else if (!en)                phase <= PHASE_SUM;
        else if (phase == PHASE_SUM) phase <= PHASE_DIFF;
        else                         phase <= PHASE_SUM;
    end

    // Output mux, inputs stay stable across both slots
    always_ff @(posedge clk) begin
        if (en) begin
            if (phase == PHASE_SUM) begin
                out_re <= sum_re;
                out_im <= sum_im;
            end else begin
                out_re <= diff_re;
                out_im <= diff_im;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_valid_d <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            in_valid_d <= in_valid;
            out_valid  <= en;    // One cycle behind the mux select
        end
    end

endmodule

//--- design/butterfly_stage.sv
`timescale 1ns/10ps

module butterfly_stage import fft_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,   // At most every other cycle
    input  sample_t             a_re,
    input  sample_t             a_im,
    input  sample_t             b_re,
    input  sample_t             b_im,
    input  logic [TW_IDX_W-1:0] tw_idx,
    output sample_t             out_re,     // Sum then difference
    output sample_t             out_im,
    output logic                out_valid
);

    prod_t   prod_re, prod_im;   // b*W^k
    logic    prod_valid;
    sample_t sum_re, sum_im;
    sample_t diff_re, diff_im;
    logic    bf_valid;

    // 3 cycles: twiddle read, multiply, scale
    twiddle_mult i_twiddle_mult (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .b_re       (b_re),
        .b_im       (b_im),
        .tw_idx     (tw_idx),
        .prod_re    (prod_re),
        .prod_im    (prod_im),
        .prod_valid (prod_valid)
    );

    // a is delayed inside to meet the product
    butterfly i_butterfly (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .a_re       (a_re),
        .a_im       (a_im),
        .prod_re    (prod_re),
        .prod_im    (prod_im),
        .prod_valid (prod_valid),
        .sum_re     (sum_re),
        .sum_im     (sum_im),
        .diff_re    (diff_re),
        .diff_im    (diff_im),
        .bf_valid   (bf_valid)
    );

    pair_serializer i_pair_serializer (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (bf_valid),
        .sum_re    (sum_re),
        .sum_im    (sum_im),
        .diff_re   (diff_re),
        .diff_im   (diff_im),
        .out_re    (out_re),
        .out_im    (out_im),
        .out_valid (out_valid)
    );

endmodule

//--- bench/tb_butterfly_stage.sv
`timescale 1ns/10ps

module tb_butterfly_stage import fft_pkg::*; ();

    localparam int          CLK_PERIOD   = 20;            // ns
    localparam int          NUM_ROWS     = 24;
    localparam int          N_DIRECTED   = 8;             // Rows 0..7, one per twiddle
    localparam int          WATCHDOG_CYC = NUM_ROWS * 3 + 40;
    localparam logic [31:0] LFSR_SEED    = 32'ha861;
    localparam logic [31:0] LFSR_TAPS    = 32'h80200003;  // x^32 + x^22 + x^2 + x + 1
    localparam real         PI           = 3.14159265358979;

    logic                clk;
    logic                rst_n;
    logic                in_valid;
    sample_t             a_re, a_im;
    sample_t             b_re, b_im;
    logic [TW_IDX_W-1:0] tw_idx;
    sample_t             out_re, out_im;
    logic                out_valid;

    // Stimulus and expected results with one entry per row
    int row_a_re [NUM_ROWS];
    int row_a_im [NUM_ROWS];
    int row_b_re [NUM_ROWS];
    int row_b_im [NUM_ROWS];
    int row_k    [NUM_ROWS];
    int row_s_re [NUM_ROWS];
    int row_s_im [NUM_ROWS];
    int row_d_re [NUM_ROWS];
    int row_d_im [NUM_ROWS];

    int          exp_re [$];       // Sum, diff, sum, diff ... in output order
    int          exp_im [$];
    int          due_cyc [$];      // Negedge count where each output must show
    int          neg_cyc = 0;
    logic [31:0] lfsr_state = LFSR_SEED;

    butterfly_stage i_butterfly_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .a_re      (a_re),
        .a_im      (a_im),
        .b_re      (b_re),
        .b_im      (b_im),
        .tw_idx    (tw_idx),
        .out_re    (out_re),
        .out_im    (out_im),
        .out_valid (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_fail(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input int expected, input int actual);
        report_fail($sformatf("FAIL at %0t: %s expected %0d, actual %0d",
                              $time, name, expected, actual));
    endtask

    // Galois step shifts right and folds the taps in on a one
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val        = (val << 1) | int'(lfsr_state[0]);   // One step per bit
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // Sign and 14-bit magnitude keep the value within +-16383
    task automatic take_sample(output int val);
        int sgn;
        int mag;
        take_bits(1, sgn);
        take_bits(14, mag);
        val = sgn ? -mag : mag;
    endtask

    function automatic longint round_q14(input real x);
        real y;
        y = x * 16384.0;
        if (y >= 0.0) return longint'($rtoi(y + 0.5));
        else          return longint'($rtoi(y - 0.5));
    endfunction

    // Reference butterfly using W^k = cos - j sin with truncating >>> 14 and halving >>> 1
    function automatic void bf_model(input int ar, ai, br, bi, k,
                                     output int s_re, s_im, d_re, d_im);
        real    ang;
        longint w_re, w_im, p_re, p_im;
        ang  = 2.0 * PI * real'(k) / real'(N_POINTS);
        w_re = round_q14($cos(ang));
        w_im = -round_q14($sin(ang));
        p_re = (longint'(br) * w_re - longint'(bi) * w_im) >>> TW_FRAC;
        p_im = (longint'(br) * w_im + longint'(bi) * w_re) >>> TW_FRAC;
        s_re = int'((longint'(ar) + p_re) >>> 1);
        s_im = int'((longint'(ai) + p_im) >>> 1);
        d_re = int'((longint'(ar) - p_re) >>> 1);
        d_im = int'((longint'(ai) - p_im) >>> 1);
    endfunction

    task automatic set_row(input int r, ar, ai, br, bi, k);
        row_a_re[r] = ar;
        row_a_im[r] = ai;
        row_b_re[r] = br;
        row_b_im[r] = bi;
        row_k[r]    = k;
    endtask

    task automatic build_table();
        int v;
        set_row(0,   1000,   1000,   8000,  -7999, 0);   // Plain (a +- b)/2 with an odd diff
        set_row(1,   1000,   1000,   8000,   8000, 1);
        set_row(2,   1000,   1000,   8000,   8000, 2);
        set_row(3,   1000,  -1000,   8000,  -8000, 3);
        set_row(4,      0,      0,      0,      0, 4);   // Zero in, zero out
        set_row(5, -16383, -16383, -16383, -16383, 5);   // Negative extreme
        set_row(6,  16383, -16383, -16383,  16383, 6);   // Largest rotated magnitude
        set_row(7, -16383,  16383,  16383,  16383, 7);
        for (int r = N_DIRECTED; r < NUM_ROWS; r++) begin
            take_sample(v);
            row_a_re[r] = v;
            take_sample(v);
            row_a_im[r] = v;
            take_sample(v);
            row_b_re[r] = v;
            take_sample(v);
            row_b_im[r] = v;
            take_bits(TW_IDX_W, v);
            row_k[r] = v;
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            bf_model(row_a_re[r], row_a_im[r], row_b_re[r], row_b_im[r], row_k[r],
                     row_s_re[r], row_s_im[r], row_d_re[r], row_d_im[r]);
        end
    endtask

    // Driver
    initial begin : driver
        int gap;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        a_re     = '0;
        a_im     = '0;
        b_re     = '0;
        b_im     = '0;
        tw_idx   = '0;
        build_table();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);                  // Idle cycle where out_valid must stay low
        for (int r = 0; r < NUM_ROWS; r++) begin
            @(posedge clk);
            in_valid <= 1'b1;
            a_re     <= sample_t'(row_a_re[r]);
            a_im     <= sample_t'(row_a_im[r]);
            b_re     <= sample_t'(row_b_re[r]);
            b_im     <= sample_t'(row_b_im[r]);
            tw_idx   <= TW_IDX_W'(row_k[r]);
            exp_re.push_back(row_s_re[r]);
            exp_im.push_back(row_s_im[r]);
            exp_re.push_back(row_d_re[r]);
            exp_im.push_back(row_d_im[r]);
            // Directed rows packed tight so two items are in flight
            if (r < N_DIRECTED) gap = 1;
            else begin
                take_bits(1, gap);
                gap = gap + 1;
            end
            repeat (gap) begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
        end
        while (exp_re.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);       // Catch any trailing out_valid
        $display("** PASS **");
        $finish;
    end

    // Monitor samples at negedge where all signals are settled
    always @(negedge clk) begin : monitor
        int act_re;
        int act_im;
        neg_cyc = neg_cyc + 1;
        if (rst_n) begin
            if (out_valid) begin
                assert (due_cyc.size() > 0 && exp_re.size() > 0)
                    else report_fail("out_valid high with no result pending");
                assert (due_cyc[0] == neg_cyc)
                    else report_fail($sformatf("out_valid at cycle %0d, due at cycle %0d",
                                               neg_cyc, due_cyc[0]));
                act_re = out_re;
                act_im = out_im;
                assert (act_re == exp_re[0]) else report_value("out_re", exp_re[0], act_re);
                assert (act_im == exp_im[0]) else report_value("out_im", exp_im[0], act_im);
                void'(due_cyc.pop_front());
                void'(exp_re.pop_front());
                void'(exp_im.pop_front());
            end else begin
                assert (due_cyc.size() == 0 || due_cyc[0] != neg_cyc)
                    else report_fail("out_valid low on a cycle where a result was due");
            end
            // Sum shows 5 negedges after the strobe and diff right behind it
            if (in_valid) begin
                due_cyc.push_back(neg_cyc + 5);
                due_cyc.push_back(neg_cyc + 6);
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYC * CLK_PERIOD);
        report_fail("Watchdog expired before all results came out");
    end

endmodule

//--- src.f
design/fft_pkg.sv
design/twiddle_rom.sv
design/twiddle_mult.sv
design/butterfly.sv
design/pair_serializer.sv
design/butterfly_stage.sv
bench/tb_butterfly_stage.sv

//--- Bender.yml
package:
  name: butterfly_stage

sources:
  - files:
      - design/fft_pkg.sv
      - design/twiddle_rom.sv
      - design/twiddle_mult.sv
      - design/butterfly.sv
      - design/pair_serializer.sv
      - design/butterfly_stage.sv
  - target: test
    files:
      - bench/tb_butterfly_stage.sv
